/* sim.f */
common/gbe_cpu_pkg.sv
common/cpu_bus_if.sv
verilog/cpu_bus_ctrl.sv
regs/buf_occ_ctrl.sv
regs/cpu_reg_file.sv
buffers/mem_rmw_port.sv
verilog/gbe_cpu_attach.sv
test/tb_mem_model.sv
test/tb_gbe_cpu_attach.sv

/* test/tb_gbe_cpu_attach.sv */
`timescale 1ns/1ps
module tb_gbe_cpu_attach;
  import gbe_cpu_pkg::*;

  localparam int          CLK_PERIOD = 40;
  localparam int          NUM_TESTS  = 6;
  localparam int          ACK_LIMIT  = 20;
  localparam logic [63:0] ARP_FILL   = 64'h0000_9e37_a5c3_1f00;
  localparam logic [63:0] TX_FILL    = 64'h0000_0000_3c3c_0000;
  localparam logic [63:0] RX_FILL    = 64'h0000_0000_5a5a_0000;

  logic        cpu_clk;
  logic        cpu_rst;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [31:0] wb_adr_i;
  logic [31:0] wb_dat_i;
  logic [3:0]  wb_sel_i;
  logic [31:0] wb_dat_o;
  logic        wb_ack_o;
  logic [47:0] local_mac_o;
  logic [31:0] local_ip_o;
  logic [7:0]  local_gateway_o;
  logic [15:0] local_port_o;
  logic        local_enable_o;
  logic        cpu_promiscuous_o;
  logic [7:0]  arp_cache_addr_o;
  logic [47:0] arp_cache_rd_data_i;
  logic [47:0] arp_cache_wr_data_o;
  logic        arp_cache_wr_en_o;
  logic [8:0]  tx_buf_addr_o;
  logic [31:0] tx_buf_rd_data_i;
  logic [31:0] tx_buf_wr_data_o;
  logic        tx_buf_wr_en_o;
  logic [8:0]  rx_buf_addr_o;
  logic [31:0] rx_buf_rd_data_i;
  logic [11:0] tx_size_o;
  logic        tx_ready_o;
  logic        tx_done_i;
  logic [11:0] rx_size_i;
  logic        rx_ready_i;
  logic        rx_ack_o;

  // expected memory contents
  logic [47:0] arp_model [256];
  logic [31:0] tx_model [512];

  integer      seed;
  int          errors;
  int          test_start;
  int          failed_tests;
  string       cur_test;

  gbe_cpu_attach i_gbe_cpu_attach (.*);

  tb_mem_model #(.DW(48), .AW(8), .FILL(ARP_FILL)) i_arp_mem (
    .cpu_clk   (cpu_clk),
    .addr_i    (arp_cache_addr_o),
    .wr_en_i   (arp_cache_wr_en_o),
    .wr_data_i (arp_cache_wr_data_o),
    .rd_data_o (arp_cache_rd_data_i)
  );

  tb_mem_model #(.DW(32), .AW(9), .FILL(TX_FILL)) i_tx_mem (
    .cpu_clk   (cpu_clk),
    .addr_i    (tx_buf_addr_o),
    .wr_en_i   (tx_buf_wr_en_o),
    .wr_data_i (tx_buf_wr_data_o),
    .rd_data_o (tx_buf_rd_data_i)
  );

  tb_mem_model #(.DW(32), .AW(9), .FILL(RX_FILL)) i_rx_mem (
    .cpu_clk   (cpu_clk),
    .addr_i    (rx_buf_addr_o),
    .wr_en_i   (1'b0),
    .wr_data_i (32'd0),
    .rd_data_o (rx_buf_rd_data_i)
  );

  initial begin
    cpu_clk = 1'b0;
    forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
  end

  task automatic compare(input string what, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp) else begin
      $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errors++;
    end
  endtask

  function automatic logic [31:0] apply_byte_mask(input logic [31:0] old_w,
                                                  input logic [31:0] new_w,
                                                  input logic [3:0]  sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b])
        res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [7:0] idx);
    return REGS_BASE + {22'd0, idx, 2'b00};
  endfunction

  // one classic cycle, ack and data sampled mid-cycle
  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, output logic [31:0] rdat, output int lat);
    int n;
    n = 0;
    @(posedge cpu_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    do begin
      @(negedge cpu_clk);
      n++;
    end while (wb_ack_o !== 1'b1 && n < ACK_LIMIT);
    assert (wb_ack_o === 1'b1) else begin
      $display("%s: no acknowledge for address %h within %0d cycles", cur_test, adr, n);
      errors++;
    end
    rdat = wb_dat_o;
    lat  = n - 1;
    @(posedge cpu_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_write(input logic [31:0] adr, input logic [31:0] dat, input logic [3:0] sel,
                          input int exp_lat);
    logic [31:0] unused;
    int          lat;
    wb_access(1'b1, adr, dat, sel, unused, lat);
    compare("write ack latency", exp_lat, lat);
  endtask

  task automatic wb_read(input logic [31:0] adr, output logic [31:0] dat);
    int lat;
    wb_access(1'b0, adr, 32'd0, 4'hf, dat, lat);
    compare("read ack latency", 1, lat);
  endtask

  task automatic wait_rx_ack(input logic level);
    int n;
    n = 0;
    while (rx_ack_o !== level && n < ACK_LIMIT) begin
      @(negedge cpu_clk);
      n++;
    end
    assert (rx_ack_o === level) else begin
      $display("%s: rx_ack_o did not reach %b within %0d cycles", cur_test, level, n);
      errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test   = name;
    test_start = errors;
  endtask

  task automatic end_test();
    if (errors == test_start) begin
      $display("test %s: passed", cur_test);
    end else begin
      $display("test %s: failed with %0d errors", cur_test, errors - test_start);
      failed_tests++;
    end
  endtask

  task automatic identity_regs();
    logic [31:0] d;
    @(negedge cpu_clk);
    compare("ack after reset", 1'b0, wb_ack_o);
    compare("write enables after reset", 2'b00, {arp_cache_wr_en_o, tx_buf_wr_en_o});
    compare("handshakes after reset", 2'b00, {tx_ready_o, rx_ack_o});
    wb_read(reg_addr(REG_CORE_TYPE), d);
    compare("core type", 32'h0001_0101, d);
    wb_read(reg_addr(REG_BUFFER_SIZE), d);
    compare("buffer size", 32'h0800_0800, d);
    wb_read(reg_addr(REG_WORD_LENGTH), d);
    compare("word length", 32'h0008_0004, d);
    wb_read(reg_addr(REG_ARP_SIZE), d);
    compare("arp size", 32'd256, d);
    wb_read(reg_addr(8'd7), d);
    compare("unlisted index", 32'd0, d);
    // outside every window
    wb_read(32'h0001_0000, d);
    compare("unmapped address", 32'd0, d);
  endtask

  task automatic check_settings(input logic [47:0] mac, input logic [31:0] ip,
                                input logic [15:0] port, input logic en, input logic pr);
    logic [31:0] d;
    @(negedge cpu_clk);
    compare("mac output", mac, local_mac_o);
    compare("ip output", ip, local_ip_o);
    compare("port output", port, local_port_o);
    compare("enable outputs", {pr, en}, {cpu_promiscuous_o, local_enable_o});
    wb_read(reg_addr(REG_LOCAL_MAC_1), d);
    compare("mac_1 readback", {16'd0, mac[47:32]}, d);
    wb_read(reg_addr(REG_LOCAL_MAC_0), d);
    compare("mac_0 readback", mac[31:0], d);
    wb_read(reg_addr(REG_LOCAL_IP), d);
    compare("ip readback", ip, d);
    wb_read(reg_addr(REG_LOCAL_PORT), d);
    compare("port readback", {16'd0, port}, d);
    wb_read(reg_addr(REG_LOCAL_ENABLE), d);
    compare("enable readback", {23'd0, pr, 7'd0, en}, d);
  endtask

  task automatic network_settings();
    logic [47:0] mac;
    logic [31:0] ip;
    logic [15:0] port;
    logic        en;
    logic        pr;
    logic [31:0] d;
    logic [31:0] dat;
    logic [31:0] tmp;
    logic [3:0]  sel;
    logic [7:0]  idx;
    mac  = MAC_DEFAULT;
    ip   = IP_DEFAULT;
    port = PORT_DEFAULT;
    en   = ENABLE_DEFAULT;
    pr   = PROMISC_DEFAULT;
    check_settings(mac, ip, port, en, pr);
    compare("gateway output", GATEWAY_DEFAULT, local_gateway_o);
    wb_read(reg_addr(REG_LOCAL_GATEWAY), d);
    compare("gateway readback", {24'd0, GATEWAY_DEFAULT}, d);
    for (int i = 0; i < 12; i++) begin
      dat = $random(seed);
      sel = $random(seed);
      case ($unsigned($random(seed)) % 5)
        0: idx = REG_LOCAL_MAC_1;
        1: idx = REG_LOCAL_MAC_0;
        2: idx = REG_LOCAL_IP;
        3: idx = REG_LOCAL_PORT;
        default: idx = REG_LOCAL_ENABLE;
      endcase
      wb_write(reg_addr(idx), dat, sel, 1);
      // only the bytes that exist in each register
      case (idx)
        REG_LOCAL_MAC_1: begin
          tmp = apply_byte_mask({16'd0, mac[47:32]}, dat, sel & 4'b0011);
          mac[47:32] = tmp[15:0];
        end
        REG_LOCAL_MAC_0: mac[31:0] = apply_byte_mask(mac[31:0], dat, sel);
        REG_LOCAL_IP: ip = apply_byte_mask(ip, dat, sel);
        REG_LOCAL_PORT: begin
          tmp  = apply_byte_mask({16'd0, port}, dat, sel & 4'b0011);
          port = tmp[15:0];
        end
        default: begin
          if (sel[0])
            en = dat[0];
          if (sel[1])
            pr = dat[8];
        end
      endcase
      check_settings(mac, ip, port, en, pr);
    end
  endtask

  task automatic arp_cache_rmw();
    logic [31:0] d;
    logic [31:0] dat;
    logic [31:0] tmp;
    logic [3:0]  sel;
    logic [7:0]  idx;
    for (int i = 0; i < 8; i++) begin
      idx = $random(seed);
      dat = $random(seed);
      sel = $random(seed);
      // offset bit 2 set is the low word of the entry
      wb_write(ARP_BASE + {idx, 3'b100}, dat, sel, 2);
      arp_model[idx][31:0] = apply_byte_mask(arp_model[idx][31:0], dat, sel);
      dat = $random(seed);
      sel = $random(seed);
      wb_write(ARP_BASE + {idx, 3'b000}, dat, sel, 2);
      tmp = apply_byte_mask({16'd0, arp_model[idx][47:32]}, dat, sel & 4'b0011);
      arp_model[idx][47:32] = tmp[15:0];
      wb_read(ARP_BASE + {idx, 3'b100}, d);
      compare("low word readback", arp_model[idx][31:0], d);
      wb_read(ARP_BASE + {idx, 3'b000}, d);
      compare("high word readback", {16'd0, arp_model[idx][47:32]}, d);
      compare("cache entry", arp_model[idx], i_arp_mem.mem[idx]);
    end
  endtask

  task automatic buffer_access();
    logic [31:0] d;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic [8:0]  idx;
    for (int i = 0; i < 6; i++) begin
      idx = $random(seed);
      dat = $random(seed);
      sel = $random(seed);
      wb_write(TX_BUF_BASE + {idx, 2'b00}, dat, sel, 2);
      tx_model[idx] = apply_byte_mask(tx_model[idx], dat, sel);
      wb_read(TX_BUF_BASE + {idx, 2'b00}, d);
      compare("tx readback", tx_model[idx], d);
      compare("tx memory word", tx_model[idx], i_tx_mem.mem[idx]);
    end
    for (int i = 0; i < 6; i++) begin
      idx = $random(seed);
      wb_read(RX_BUF_BASE + {idx, 2'b00}, d);
      compare("rx pattern", {23'd0, idx} ^ 32'h5a5a_0000, d);
    end
    // rx window is read only
    wb_write(RX_BUF_BASE + {idx, 2'b00}, $random(seed), 4'hf, 1);
    wb_read(RX_BUF_BASE + {idx, 2'b00}, d);
    compare("rx after write", {23'd0, idx} ^ 32'h5a5a_0000, d);
    // same offset would hit these words if the write leaked to another memory
    compare("tx memory after rx write", tx_model[idx], i_tx_mem.mem[idx]);
    compare("arp entry after rx write", arp_model[idx[8:1]], i_arp_mem.mem[idx[8:1]]);
  endtask

  task automatic tx_handshake();
    logic [31:0] d;
    logic [11:0] size;
    size = $random(seed);
    wb_write(reg_addr(REG_BUFFER_OCC), {4'd0, size, 16'd0}, 4'b1100, 1);
    @(negedge cpu_clk);
    compare("tx_ready_o after size write", 1'b1, tx_ready_o);
    compare("tx_size_o after size write", size, tx_size_o);
    wb_read(reg_addr(REG_BUFFER_OCC), d);
    compare("occupancy tx size", size, d[27:16]);
    @(posedge cpu_clk);
    tx_done_i <= 1'b1;
    @(posedge cpu_clk);
    tx_done_i <= 1'b0;
    @(negedge cpu_clk);
    compare("tx_ready_o after done", 1'b0, tx_ready_o);
    compare("tx_size_o after done", 12'd0, tx_size_o);
    wb_read(reg_addr(REG_BUFFER_OCC), d);
    compare("occupancy tx size after done", 12'd0, d[27:16]);
  endtask

  task automatic rx_handshake();
    logic [31:0] d;
    logic [11:0] size;
    size = $random(seed) & 12'h7ff;
    @(posedge cpu_clk);
    rx_size_i  <= size;
    rx_ready_i <= 1'b1;
    wait_rx_ack(1'b1);
    wait_rx_ack(1'b0);
    wb_read(reg_addr(REG_BUFFER_OCC), d);
    compare("occupancy rx size", size + 12'd1, d[11:0]);
    @(negedge cpu_clk);
    compare("rx_ack_o while buffer held", 1'b0, rx_ack_o);
    // ack pulse for the next frame comes while the release write finishes
    fork
      wb_write(reg_addr(REG_BUFFER_OCC), 32'd0, 4'b0011, 1);
      wait_rx_ack(1'b1);
    join
    wait_rx_ack(1'b0);
    @(posedge cpu_clk);
    rx_ready_i <= 1'b0;
  endtask

  initial begin
    seed         = 32'h6e9ae8d6;
    errors       = 0;
    failed_tests = 0;
    cpu_rst    <= 1'b1;
    wb_cyc_i   <= 1'b0;
    wb_stb_i   <= 1'b0;
    wb_we_i    <= 1'b0;
    wb_adr_i   <= 32'd0;
    wb_dat_i   <= 32'd0;
    wb_sel_i   <= 4'd0;
    tx_done_i  <= 1'b0;
    rx_size_i  <= 12'd0;
    rx_ready_i <= 1'b0;
    for (int i = 0; i < 256; i++) begin
      arp_model[i] = ARP_FILL[47:0] ^ 48'(i);
    end
    for (int i = 0; i < 512; i++) begin
      tx_model[i] = TX_FILL[31:0] ^ 32'(i);
    end
    repeat (10) @(posedge cpu_clk);
    cpu_rst <= 1'b0;

    begin_test("identity");
    identity_regs();
    end_test();
    begin_test("settings");
    network_settings();
    end_test();
    begin_test("arp_cache");
    arp_cache_rmw();
    end_test();
    begin_test("buffers");
    buffer_access();
    end_test();
    begin_test("tx_handshake");
    tx_handshake();
    end_test();
    begin_test("rx_handshake");
    rx_handshake();
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // generous bound per test
  initial begin
    #(NUM_TESTS * 2000 * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", NUM_TESTS * 2000);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* test/tb_mem_model.sv */
`timescale 1ns/1ps
module tb_mem_model #(
  parameter int          DW   = 32,
  parameter int          AW   = 9,
  parameter logic [63:0] FILL = 64'd0
) (
  input  logic          cpu_clk,
  input  logic [AW-1:0] addr_i,
  input  logic          wr_en_i,
  input  logic [DW-1:0] wr_data_i,
  output logic [DW-1:0] rd_data_o
);

  logic [DW-1:0] mem [2**AW];

  // every word differs, so a wrong address shows up in the data
  initial begin
    logic [63:0] word;
    for (int i = 0; i < 2**AW; i++) begin
      word   = FILL ^ 64'(i);
      mem[i] = word[DW-1:0];
    end
  end

  // synchronous read, one cycle latency
  always @(posedge cpu_clk) begin
    if (wr_en_i)
      mem[addr_i] <= wr_data_i;
    rd_data_o <= mem[addr_i];
  end

endmodule

/* verilog/gbe_cpu_attach.sv */
`timescale 1ns/1ps
module gbe_cpu_attach (
  input  logic                               cpu_clk,
  input  logic                               cpu_rst,
  // wishbone slave
  input  logic                               wb_cyc_i,
  input  logic                               wb_stb_i,
  input  logic                               wb_we_i,
  input  logic [31:0]                        wb_adr_i,
  input  logic [31:0]                        wb_dat_i,
  input  logic [3:0]                         wb_sel_i,
  output logic [31:0]                        wb_dat_o,
  output logic                               wb_ack_o,
  // network settings
  output logic [gbe_cpu_pkg::MAC_W-1:0]      local_mac_o,
  output logic [31:0]                        local_ip_o,
  output logic [7:0]                         local_gateway_o,
  output logic [15:0]                        local_port_o,
  output logic                               local_enable_o,
  output logic                               cpu_promiscuous_o,
  // arp cache
  output logic [gbe_cpu_pkg::ARP_ADDR_W-1:0] arp_cache_addr_o,
  input  logic [gbe_cpu_pkg::MAC_W-1:0]      arp_cache_rd_data_i,
  output logic [gbe_cpu_pkg::MAC_W-1:0]      arp_cache_wr_data_o,
  output logic                               arp_cache_wr_en_o,
  // tx buffer
  output logic [gbe_cpu_pkg::BUF_ADDR_W-1:0] tx_buf_addr_o,
  input  logic [31:0]                        tx_buf_rd_data_i,
  output logic [31:0]                        tx_buf_wr_data_o,
  output logic                               tx_buf_wr_en_o,
  // rx buffer
  output logic [gbe_cpu_pkg::BUF_ADDR_W-1:0] rx_buf_addr_o,
  input  logic [31:0]                        rx_buf_rd_data_i,
  // packet handshakes
  output logic [gbe_cpu_pkg::SIZE_W-1:0]     tx_size_o,
  output logic                               tx_ready_o,
  input  logic                               tx_done_i,
  input  logic [gbe_cpu_pkg::SIZE_W-1:0]     rx_size_i,
  input  logic                               rx_ready_i,
  output logic                               rx_ack_o
);

  logic [31:0] reg_rdata;
  logic [31:0] mem_rdata;

  cpu_bus_if i_cpu_bus ();

  cpu_bus_ctrl i_cpu_bus_ctrl (
    .cpu_clk     (cpu_clk),
    .cpu_rst     (cpu_rst),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .wb_dat_o    (wb_dat_o),
    .wb_ack_o    (wb_ack_o),
    .bus         (i_cpu_bus.ctrl),
    .reg_rdata_i (reg_rdata),
    .mem_rdata_i (mem_rdata)
  );

  cpu_reg_file i_cpu_reg_file (
    .cpu_clk           (cpu_clk),
    .cpu_rst           (cpu_rst),
    .bus               (i_cpu_bus.target),
    .reg_rdata_o       (reg_rdata),
    .local_mac_o       (local_mac_o),
    .local_ip_o        (local_ip_o),
    .local_gateway_o   (local_gateway_o),
    .local_port_o      (local_port_o),
    .local_enable_o    (local_enable_o),
    .cpu_promiscuous_o (cpu_promiscuous_o),
    .tx_done_i         (tx_done_i),
    .tx_size_o         (tx_size_o),
    .tx_ready_o        (tx_ready_o),
    .rx_size_i         (rx_size_i),
    .rx_ready_i        (rx_ready_i),
    .rx_ack_o          (rx_ack_o)
  );

  mem_rmw_port i_mem_rmw_port (
    .cpu_clk             (cpu_clk),
    .cpu_rst             (cpu_rst),
    .bus                 (i_cpu_bus.target),
    .mem_rdata_o         (mem_rdata),
    .arp_cache_addr_o    (arp_cache_addr_o),
    .arp_cache_rd_data_i (arp_cache_rd_data_i),
    .arp_cache_wr_data_o (arp_cache_wr_data_o),
    .arp_cache_wr_en_o   (arp_cache_wr_en_o),
    .tx_buf_addr_o       (tx_buf_addr_o),
    .tx_buf_rd_data_i    (tx_buf_rd_data_i),
    .tx_buf_wr_data_o    (tx_buf_wr_data_o),
    .tx_buf_wr_en_o      (tx_buf_wr_en_o),
    .rx_buf_addr_o       (rx_buf_addr_o),
    .rx_buf_rd_data_i    (rx_buf_rd_data_i)
  );

endmodule

/* buffers/mem_rmw_port.sv */
`timescale 1ns/1ps
module mem_rmw_port (
  input  logic                               cpu_clk,
  input  logic                               cpu_rst,
  cpu_bus_if.target                          bus,
  output logic [31:0]                        mem_rdata_o,
  output logic [gbe_cpu_pkg::ARP_ADDR_W-1:0] arp_cache_addr_o,
  input  logic [gbe_cpu_pkg::MAC_W-1:0]      arp_cache_rd_data_i,
  output logic [gbe_cpu_pkg::MAC_W-1:0]      arp_cache_wr_data_o,
  output logic                               arp_cache_wr_en_o,
  output logic [gbe_cpu_pkg::BUF_ADDR_W-1:0] tx_buf_addr_o,
  input  logic [31:0]                        tx_buf_rd_data_i,
  output logic [31:0]                        tx_buf_wr_data_o,
  output logic                               tx_buf_wr_en_o,
  output logic [gbe_cpu_pkg::BUF_ADDR_W-1:0] rx_buf_addr_o,
  input  logic [31:0]                        rx_buf_rd_data_i
);
  import gbe_cpu_pkg::*;

  logic [MAC_W-1:0] arp_new;
  logic [5:0]       arp_be;
  logic [MAC_W-1:0] arp_merged;
  logic [MAC_W-1:0] tx_merged;
  logic [MAC_W-1:0] wr_data_q;

  function automatic logic [MAC_W-1:0] merge_bytes(input logic [MAC_W-1:0] old_word,
                                                   input logic [MAC_W-1:0] new_word,
                                                   input logic [5:0]       be);
    logic [MAC_W-1:0] res;
    res = old_word;
    for (int b = 0; b < 6; b++) begin
      if (be[b])
        res[8*b +: 8] = new_word[8*b +: 8];
    end
    return res;
  endfunction

  // arp entries are two words apart: bit 2 set is the low word
  assign arp_cache_addr_o = bus.offset[10:3];
  assign tx_buf_addr_o    = bus.offset[10:2];
  assign rx_buf_addr_o    = bus.offset[10:2];

  assign arp_new    = bus.offset[2] ? {16'd0, bus.wdata} : {bus.wdata[15:0], 32'd0};
  assign arp_be     = bus.offset[2] ? {2'b00, bus.sel} : {bus.sel[1:0], 4'b0000};
  assign arp_merged = merge_bytes(arp_cache_rd_data_i, arp_new, arp_be);
  assign tx_merged  = merge_bytes({16'd0, tx_buf_rd_data_i}, {16'd0, bus.wdata},
                                  {2'b00, bus.sel});

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      arp_cache_wr_en_o <= 1'b0;
      tx_buf_wr_en_o    <= 1'b0;
    end else begin
      arp_cache_wr_en_o <= bus.wait_wr && bus.region == REGION_ARP;
      tx_buf_wr_en_o    <= bus.wait_wr && bus.region == REGION_TX;
    end
  end

  // read data arrives during the wait cycle
  always_ff @(posedge cpu_clk) begin
    if (bus.wait_wr)
      wr_data_q <= (bus.region == REGION_ARP) ? arp_merged : tx_merged;
  end

  assign arp_cache_wr_data_o = wr_data_q;
  assign tx_buf_wr_data_o    = wr_data_q[31:0];

  always_comb begin
    case (bus.region)
      REGION_ARP: mem_rdata_o = bus.offset[2] ? arp_cache_rd_data_i[31:0]
                                              : {16'd0, arp_cache_rd_data_i[47:32]};
      REGION_TX:  mem_rdata_o = tx_buf_rd_data_i;
      REGION_RX:  mem_rdata_o = rx_buf_rd_data_i;
      default:    mem_rdata_o = 32'd0;
    endcase
  end

  // each write lands while the master still holds its own window
  // so the two enables are never high together
  assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    arp_cache_wr_en_o |-> bus.region == REGION_ARP);
  assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    tx_buf_wr_en_o |-> bus.region == REGION_TX);

endmodule

/* regs/cpu_reg_file.sv */
`timescale 1ns/1ps
module cpu_reg_file (
  input  logic                           cpu_clk,
  input  logic                           cpu_rst,
  cpu_bus_if.target                      bus,
  output logic [31:0]                    reg_rdata_o,
  output logic [gbe_cpu_pkg::MAC_W-1:0]  local_mac_o,
  output logic [31:0]                    local_ip_o,
  output logic [7:0]                     local_gateway_o,
  output logic [15:0]                    local_port_o,
  output logic                           local_enable_o,
  output logic                           cpu_promiscuous_o,
  input  logic                           tx_done_i,
  output logic [gbe_cpu_pkg::SIZE_W-1:0] tx_size_o,
  output logic                           tx_ready_o,
  input  logic [gbe_cpu_pkg::SIZE_W-1:0] rx_size_i,
  input  logic                           rx_ready_i,
  output logic                           rx_ack_o
);
  import gbe_cpu_pkg::*;

  logic        reg_req;
  logic        reg_wr;
  reg_idx_e    req_idx;
  reg_idx_e    idx_q;
  logic [31:0] occ_word;

  assign reg_req = bus.req && bus.region == REGION_REGS;
  assign reg_wr  = reg_req && bus.we;
  assign req_idx = reg_idx_e'(bus.offset[9:2]);

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      idx_q             <= REG_CORE_TYPE;
      local_mac_o       <= MAC_DEFAULT;
      local_ip_o        <= IP_DEFAULT;
      local_gateway_o   <= GATEWAY_DEFAULT;
      local_port_o      <= PORT_DEFAULT;
      local_enable_o    <= ENABLE_DEFAULT;
      cpu_promiscuous_o <= PROMISC_DEFAULT;
    end else begin
      // read data source for the following ack cycle
      if (reg_req) begin
        idx_q <= req_idx;
      end
      if (reg_wr) begin
        case (req_idx)
          REG_LOCAL_MAC_1: begin
            for (int b = 0; b < 2; b++) begin
              if (bus.sel[b])
                local_mac_o[32+8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end
          REG_LOCAL_MAC_0: begin
            for (int b = 0; b < 4; b++) begin
              if (bus.sel[b])
                local_mac_o[8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end
          REG_LOCAL_IP: begin
            for (int b = 0; b < 4; b++) begin
              if (bus.sel[b])
                local_ip_o[8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end
          REG_LOCAL_GATEWAY: begin
            if (bus.sel[0])
              local_gateway_o <= bus.wdata[7:0];
          end
          REG_LOCAL_ENABLE: begin
            if (bus.sel[0])
              local_enable_o <= bus.wdata[0];
            if (bus.sel[1])
              cpu_promiscuous_o <= bus.wdata[8];
          end
          REG_LOCAL_PORT: begin
            for (int b = 0; b < 2; b++) begin
              if (bus.sel[b])
                local_port_o[8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_comb begin
    case (idx_q)
      // rx enable shares bit 8 with the revision field
      REG_CORE_TYPE: reg_rdata_o = {15'd0, CPU_TX_EN,
                                    CORE_REVISION | {7'd0, CPU_RX_EN}, CORE_TYPE};
      REG_BUFFER_SIZE:   reg_rdata_o = {TX_BUF_BYTES, RX_BUF_BYTES};
      REG_WORD_LENGTH:   reg_rdata_o = {TX_WORD_BYTES, RX_WORD_BYTES};
      REG_LOCAL_MAC_1:   reg_rdata_o = {16'd0, local_mac_o[47:32]};
      REG_LOCAL_MAC_0:   reg_rdata_o = local_mac_o[31:0];
      REG_LOCAL_IP:      reg_rdata_o = local_ip_o;
      REG_LOCAL_GATEWAY: reg_rdata_o = {24'd0, local_gateway_o};
      REG_BUFFER_OCC:    reg_rdata_o = occ_word;
      REG_LOCAL_ENABLE:  reg_rdata_o = {23'd0, cpu_promiscuous_o, 7'd0, local_enable_o};
      REG_LOCAL_PORT:    reg_rdata_o = {16'd0, local_port_o};
      REG_ARP_SIZE:      reg_rdata_o = ARP_ENTRIES;
      default:           reg_rdata_o = 32'd0;
    endcase
  end

  buf_occ_ctrl i_buf_occ_ctrl (
    .cpu_clk    (cpu_clk),
    .cpu_rst    (cpu_rst),
    .bus        (bus),
    .occ_word_o (occ_word),
    .tx_done_i  (tx_done_i),
    .tx_size_o  (tx_size_o),
    .tx_ready_o (tx_ready_o),
    .rx_size_i  (rx_size_i),
    .rx_ready_i (rx_ready_i),
    .rx_ack_o   (rx_ack_o)
  );

endmodule

/* regs/buf_occ_ctrl.sv */
`timescale 1ns/1ps
module buf_occ_ctrl (
  input  logic                           cpu_clk,
  input  logic                           cpu_rst,
  cpu_bus_if.target                      bus,
  output logic [31:0]                    occ_word_o,
  input  logic                           tx_done_i,
  output logic [gbe_cpu_pkg::SIZE_W-1:0] tx_size_o,
  output logic                           tx_ready_o,
  input  logic [gbe_cpu_pkg::SIZE_W-1:0] rx_size_i,
  input  logic                           rx_ready_i,
  output logic                           rx_ack_o
);
  import gbe_cpu_pkg::*;

  logic              occ_wr;
  logic [SIZE_W-1:0] rx_size_q;

  assign occ_wr = bus.req && bus.we && bus.region == REGION_REGS &&
                  bus.offset[9:2] == REG_BUFFER_OCC;

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      tx_size_o  <= '0;
      tx_ready_o <= 1'b0;
      rx_size_q  <= '0;
      rx_ack_o   <= 1'b0;
    end else begin
      // transmitter has taken the frame
      if (tx_done_i) begin
        tx_size_o  <= '0;
        tx_ready_o <= 1'b0;
      end
      // cpu side empty, ask for the next received frame
      if (rx_size_q == '0 && rx_ready_i)
        rx_ack_o <= 1'b1;
      if (rx_ready_i && rx_ack_o) begin
        rx_size_q <= rx_size_i + 1'b1;
        rx_ack_o  <= 1'b0;
      end
      // cpu writes win over the handshakes
      if (occ_wr) begin
        if (bus.sel[0])
          rx_size_q[7:0] <= bus.wdata[7:0];
        if (bus.sel[1])
          rx_size_q[11:8] <= bus.wdata[11:8];
        if (bus.sel[2]) begin
          tx_size_o[7:0] <= bus.wdata[23:16];
          tx_ready_o     <= 1'b1;
        end
        if (bus.sel[3])
          tx_size_o[11:8] <= bus.wdata[27:24];
      end
    end
  end

  assign occ_word_o = {4'd0, tx_size_o, 4'd0, rx_size_q};

  // accepted frame loads its size and drops ack in the same step
  assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    rx_ready_i && rx_ack_o && !(occ_wr && bus.sel[1:0] != 2'b00)
    |=> !rx_ack_o && rx_size_q == $past(rx_size_i) + 12'd1);

endmodule

/* verilog/cpu_bus_ctrl.sv */
`timescale 1ns/1ps
module cpu_bus_ctrl (
  input  logic        cpu_clk,
  input  logic        cpu_rst,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [31:0] wb_adr_i,
  input  logic [31:0] wb_dat_i,
  input  logic [3:0]  wb_sel_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  cpu_bus_if.ctrl     bus,
  input  logic [31:0] reg_rdata_i,
  input  logic [31:0] mem_rdata_i
);
  import gbe_cpu_pkg::*;

  region_e     region;
  region_e     src_q;
  logic [31:0] base;
  logic [31:0] rel_addr;
  logic        req;
  logic        mem_wr;
  logic        ack_q;
  logic        wait_q;

  // window decode
  always_comb begin
    region = REGION_NONE;
    base   = REGS_BASE;
    if (wb_adr_i >= REGS_BASE && wb_adr_i <= REGS_HIGH) begin
      region = REGION_REGS;
    end else if (wb_adr_i >= ARP_BASE && wb_adr_i <= ARP_HIGH) begin
      region = REGION_ARP;
      base   = ARP_BASE;
    end else if (wb_adr_i >= TX_BUF_BASE && wb_adr_i <= TX_BUF_HIGH) begin
      region = REGION_TX;
      base   = TX_BUF_BASE;
    end else if (wb_adr_i >= RX_BUF_BASE && wb_adr_i <= RX_BUF_HIGH) begin
      region = REGION_RX;
      base   = RX_BUF_BASE;
    end
  end

  assign rel_addr = wb_adr_i - base;

  // master holds the cycle until ack, so nothing new during wait or ack
  assign req    = wb_cyc_i && wb_stb_i && !ack_q && !wait_q;
  assign mem_wr = wb_we_i && (region == REGION_ARP || region == REGION_TX);

  assign bus.req     = req;
  assign bus.wait_wr = wait_q;
  assign bus.we      = wb_we_i;
  assign bus.sel     = wb_sel_i;
  assign bus.region  = region;
  assign bus.offset  = rel_addr[15:0];
  assign bus.wdata   = wb_dat_i;

  always_ff @(posedge cpu_clk) begin
    if (cpu_rst) begin
      ack_q  <= 1'b0;
      wait_q <= 1'b0;
      src_q  <= REGION_NONE;
    end else begin
      // arp/tx writes take one extra cycle for the read-modify-write
      ack_q  <= (req && !mem_wr) || wait_q;
      wait_q <= req && mem_wr;
      if (req) begin
        src_q <= region;
      end
    end
  end

  assign wb_ack_o = ack_q;

  always_comb begin
    case (src_q)
      REGION_REGS: wb_dat_o = reg_rdata_i;
      REGION_ARP, REGION_TX, REGION_RX: wb_dat_o = mem_rdata_i;
      default: wb_dat_o = 32'd0;
    endcase
  end

  // ack is a single pulse per transaction
  assert property (@(posedge cpu_clk) disable iff (cpu_rst) wb_ack_o |=> !wb_ack_o);

  // wait cycle only inside an arp/tx write that the master still holds
  assert property (@(posedge cpu_clk) disable iff (cpu_rst)
    bus.wait_wr |-> mem_wr && $stable(wb_adr_i));

endmodule

/* common/cpu_bus_if.sv */
`timescale 1ns/1ps
interface cpu_bus_if;
  import gbe_cpu_pkg::*;

  // request accepted this cycle
  logic        req;
  // second cycle of an arp/tx write
  logic        wait_wr;
  logic        we;
  logic [3:0]  sel;
  region_e     region;
  // address relative to the window base
  logic [15:0] offset;
  logic [31:0] wdata;

  modport ctrl (
    output req, wait_wr, we, sel, region, offset, wdata
  );

  modport target (
    input req, wait_wr, we, sel, region, offset, wdata
  );

endinterface

/* common/gbe_cpu_pkg.sv */
package gbe_cpu_pkg;

  // cpu address windows, byte addresses
  localparam logic [31:0] REGS_BASE   = 32'h0000_0000;
  localparam logic [31:0] ARP_BASE    = 32'h0000_1000;
  localparam logic [31:0] TX_BUF_BASE = 32'h0000_4000;
  localparam logic [31:0] RX_BUF_BASE = 32'h0000_8000;

  localparam logic [31:0] REGS_HIGH   = 32'h0000_0FFF;
  localparam logic [31:0] ARP_HIGH    = 32'h0000_3FFF;
  localparam logic [31:0] TX_BUF_HIGH = 32'h0000_7FFF;
  localparam logic [31:0] RX_BUF_HIGH = 32'h0000_BFFF;

  localparam int ARP_ADDR_W = 8;
  localparam int BUF_ADDR_W = 9;
  localparam int MAC_W      = 48;
  localparam int SIZE_W     = 12;

  // identity values reported to software
  localparam logic [7:0]  CORE_TYPE     = 8'd1;
  localparam logic [7:0]  CORE_REVISION = 8'd1;
  localparam logic [15:0] TX_BUF_BYTES  = 16'd2048;
  localparam logic [15:0] RX_BUF_BYTES  = 16'd2048;
  localparam logic [15:0] TX_WORD_BYTES = 16'd8;
  localparam logic [15:0] RX_WORD_BYTES = 16'd4;
  localparam logic [31:0] ARP_ENTRIES   = 32'd256;
  localparam logic        CPU_TX_EN     = 1'b1;
  localparam logic        CPU_RX_EN     = 1'b1;

  // network settings after reset
  localparam logic [47:0] MAC_DEFAULT     = 48'h0200_0a0b_0c0d;
  localparam logic [31:0] IP_DEFAULT      = 32'hc0a8_0a0a;
  localparam logic [15:0] PORT_DEFAULT    = 16'd10000;
  localparam logic [7:0]  GATEWAY_DEFAULT = 8'd1;
  localparam logic        ENABLE_DEFAULT  = 1'b0;
  localparam logic        PROMISC_DEFAULT = 1'b0;

  typedef enum logic [2:0] {
    REGION_NONE,
    REGION_REGS,
    REGION_ARP,
    REGION_TX,
    REGION_RX
  } region_e;

  // register word index, address bits 9:2
  typedef enum logic [7:0] {
    REG_CORE_TYPE     = 8'd0,
    REG_BUFFER_SIZE   = 8'd1,
    REG_WORD_LENGTH   = 8'd2,
    REG_LOCAL_MAC_1   = 8'd3,
    REG_LOCAL_MAC_0   = 8'd4,
    REG_LOCAL_IP      = 8'd5,
    REG_LOCAL_GATEWAY = 8'd6,
    REG_BUFFER_OCC    = 8'd9,
    REG_LOCAL_ENABLE  = 8'd10,
    REG_LOCAL_PORT    = 8'd11,
    REG_ARP_SIZE      = 8'd16
  } reg_idx_e;

endpackage
